// File: mul_cases.txt
// First word is the number of cases
// Then one case per line: x y approx_product (hex)
0000000B
00000040 00000003 FFFF80C0
00000100 0000FFFE FFFF7E00
00001000 00001234 0122C000
0000FFC0 00000100 FFFF4000
00000001 00001234 FFFF8010
00000001 0000FFFF FFFF8010
00000001 00007FFF FFFF8010
00000001 00000020 FFFF8000
00000000 00000000 FFFF8000
00008000 00007FFF C0000000
00008000 00008000 3FFF8000

// File: sources.f
approx_pkg.sv
approx_signed_mul.sv
err_metrics.sv
apb_regs.sv
approx_mul_top.sv
tb_approx_mul.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --top-module tb_approx_mul -f sources.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

out=$(./obj_dir/Vtb_approx_mul)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$out" | grep -qF '*** PASSED ***'; then
    exit 0
fi
exit 1

// File: tb_approx_mul.sv
`timescale 1ns/100ps

module tb_approx_mul;

    localparam int MAX_WORDS = 1 + 3 * 64;

    logic        clk;
    logic        rst;
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [7:0]  paddr;
    logic [31:0] pwdata;
    logic [31:0] prdata;
    logic        pready;
    logic        pslverr;

    logic [31:0] mem [MAX_WORDS];   // Count word, then x, y, approx per case
    int          n_cases;
    int          cycles;
    int          limit;
    int          errors;
    int          err_at_start;
    int          pass_count;
    int          fail_count;
    logic        pslverr_seen;

    // Reference statistics kept by the testbench
    logic [31:0] exp_sum;
    logic [31:0] exp_max;
    logic [31:0] exp_count;
    logic [31:0] last_exact;   // Exact product of the latest case

    approx_mul_top dut0 (
        .clk     (clk),
        .rst     (rst),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .paddr   (paddr),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (limit > 0 && cycles >= limit) begin
            $display("Timeout: the run did not finish within %0d cycles", limit);
            $display("*** FAILED ***");
            $finish;
        end
    end

    ////////////////////
    // APB and checks
    ////////////////////

    task automatic apb_xfer(input logic wr, input logic [7:0] addr, input logic [31:0] data,
                            output logic [31:0] rdata, output logic err);
        @(posedge clk);
        psel    <= 1'b1;
        penable <= 1'b0;
        pwrite  <= wr;
        paddr   <= addr;
        pwdata  <= data;
        @(posedge clk);
        penable <= 1'b1;
        @(negedge clk);
        check_value("pready", {31'b0, pready}, 32'h1);   // Zero wait state slave
        rdata = prdata;
        err   = pslverr;
        @(posedge clk);
        psel    <= 1'b0;
        penable <= 1'b0;
    endtask

    task automatic check_value(input string name, input logic [31:0] observed,
                               input logic [31:0] expected);
        if (observed !== expected) begin
            $display("[FAIL] %0t %s observed %h expected %h", $time, name, observed, expected);
            errors++;
        end
    endtask

    task automatic apb_write(input logic [7:0] addr, input logic [31:0] data,
                             input logic exp_err);
        logic [31:0] rd;
        logic        err;
        apb_xfer(1'b1, addr, data, rd, err);
        check_value("pslverr", {31'b0, err}, {31'b0, exp_err});
    endtask

    task automatic apb_read(input logic [7:0] addr, output logic [31:0] data);
        logic err;
        apb_xfer(1'b0, addr, 32'h0, data, err);
        check_value("pslverr", {31'b0, err}, 32'h0);
    endtask

    task automatic expect_read(input string name, input logic [7:0] addr,
                               input logic [31:0] expected);
        logic [31:0] rd;
        apb_read(addr, rd);
        check_value(name, rd, expected);
    endtask

    task automatic begin_test();
        err_at_start = errors;
    endtask

    task automatic finish_test(input string name);
        if (errors == err_at_start) begin
            pass_count++;
            $display("test %s: ok", name);
        end else begin
            fail_count++;
            $display("test %s: failed", name);
        end
    endtask

    // Writes one case and checks both products, then updates the model
    task automatic run_case(input int idx);
        logic signed [15:0] x;
        logic signed [15:0] y;
        logic signed [31:0] exact;
        logic [31:0]        approx;
        longint             diff;
        logic [32:0]        s;
        x      = mem[1 + 3 * idx][15:0];
        y      = mem[2 + 3 * idx][15:0];
        approx = mem[3 + 3 * idx];
        exact  = x * y;
        last_exact = exact;
        apb_write(approx_pkg::REG_OP_X, {16'h0, x}, 1'b0);
        apb_write(approx_pkg::REG_OP_Y, {16'h0, y}, 1'b0);
        expect_read("approx", approx_pkg::REG_APPROX, approx);
        expect_read("exact", approx_pkg::REG_EXACT, exact);
        diff = longint'($signed(approx)) - longint'(exact);
        if (diff < 0)
            diff = -diff;
        s = {1'b0, exp_sum} + {1'b0, diff[31:0]};
        exp_sum = s[32] ? 32'hFFFF_FFFF : s[31:0];   // Sticks at all ones
        if (diff[31:0] > exp_max)
            exp_max = diff[31:0];
        exp_count++;
    endtask

    task automatic check_stats();
        expect_read("err_sum", approx_pkg::REG_ERR_SUM, exp_sum);
        expect_read("err_max", approx_pkg::REG_ERR_MAX, exp_max);
        expect_read("count", approx_pkg::REG_COUNT, exp_count);
    endtask

    ////////////////////
    // Test sequence
    ////////////////////

    initial begin
        logic [31:0] snap [8];
        logic [31:0] rd;
        psel       = 1'b0;
        penable    = 1'b0;
        pwrite     = 1'b0;
        paddr      = '0;
        pwdata     = '0;
        rst        = 1'b1;
        cycles     = 0;
        limit      = 0;
        errors     = 0;
        pass_count = 0;
        fail_count = 0;
        exp_sum    = '0;
        exp_max    = '0;
        exp_count  = '0;
        last_exact = '0;

        $readmemh("mul_cases.txt", mem);
        n_cases = mem[0];
        limit   = n_cases * 12 + 200;

        repeat (10) @(posedge clk);
        rst <= 1'b0;

        begin_test();
        for (int a = 0; a < 8; a++)
            expect_read("reset value", 8'(a * 4), 32'h0);
        finish_test("reset");

        begin_test();
        apb_write(approx_pkg::REG_OP_X, 32'hABCD_8001, 1'b0);
        apb_write(approx_pkg::REG_OP_Y, 32'h1234_7FFE, 1'b0);
        expect_read("op_x", approx_pkg::REG_OP_X, 32'hFFFF_8001);
        expect_read("op_y", approx_pkg::REG_OP_Y, 32'h0000_7FFE);
        apb_write(approx_pkg::REG_CTRL, 32'h1, 1'b0);   // Drop that sample
        check_stats();
        finish_test("operand readback");

        begin_test();
        for (int c = 0; c < n_cases; c++)
            run_case(c);
        finish_test("cases");

        begin_test();
        check_stats();
        finish_test("statistics");

        begin_test();
        apb_write(approx_pkg::REG_CTRL, 32'h1 << approx_pkg::CTRL_CLEAR_BIT, 1'b0);
        exp_sum   = '0;
        exp_max   = '0;
        exp_count = '0;
        check_stats();
        expect_read("approx kept", approx_pkg::REG_APPROX, mem[3 * n_cases]);
        expect_read("exact kept", approx_pkg::REG_EXACT, last_exact);
        run_case(0);
        check_stats();
        finish_test("clear");

        begin_test();
        for (int a = 0; a < 8; a++)
            apb_read(8'(a * 4), snap[a]);
        apb_write(8'h20, 32'hDEAD_BEEF, 1'b1);
        apb_write(approx_pkg::REG_APPROX, 32'h1234_5678, 1'b1);
        apb_xfer(1'b0, 8'h24, 32'h0, rd, pslverr_seen);
        check_value("pslverr", {31'b0, pslverr_seen}, 32'h1);
        for (int a = 0; a < 8; a++)
            expect_read("unchanged", 8'(a * 4), snap[a]);
        finish_test("bus errors");

        $display("tests passed %0d failed %0d", pass_count, fail_count);
        if (fail_count == 0 && errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

// File: approx_mul_top.sv
`timescale 1ns/100ps

module approx_mul_top (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            psel,
    input  logic                            penable,
    input  logic                            pwrite,
    input  logic [approx_pkg::ADDR_W-1:0]   paddr,
    input  logic [approx_pkg::PROD_W-1:0]   pwdata,
    output logic [approx_pkg::PROD_W-1:0]   prdata,
    output logic                            pready,
    output logic                            pslverr
);

    logic [approx_pkg::OP_W-1:0]   op_x;
    logic [approx_pkg::OP_W-1:0]   op_y;
    logic                          start;
    logic                          clear;
    logic [approx_pkg::PROD_W-1:0] approx_prod;    // Combinational, no latency
    logic [approx_pkg::PROD_W-1:0] approx_q;
    logic [approx_pkg::PROD_W-1:0] exact_q;
    logic [approx_pkg::PROD_W-1:0] err_sum;
    logic [approx_pkg::PROD_W-1:0] err_max;
    logic [approx_pkg::PROD_W-1:0] sample_count;

    ////////////////////
    // Bus side
    ////////////////////

    apb_regs u_regs (
        .clk          (clk),
        .rst          (rst),
        .psel         (psel),
        .penable      (penable),
        .pwrite       (pwrite),
        .paddr        (paddr),
        .pwdata       (pwdata),
        .prdata       (prdata),
        .pready       (pready),
        .pslverr      (pslverr),
        .op_x         (op_x),
        .op_y         (op_y),
        .start        (start),
        .clear        (clear),
        .approx_q     (approx_q),
        .exact_q      (exact_q),
        .err_sum      (err_sum),
        .err_max      (err_max),
        .sample_count (sample_count)
    );

    ////////////////////
    // Datapath
    ////////////////////

    approx_signed_mul u_mul (
        .x (op_x),
        .y (op_y),
        .z (approx_prod)
    );

    err_metrics u_metrics (
        .clk          (clk),
        .rst          (rst),
        .start        (start),
        .clear        (clear),
        .op_x         (op_x),
        .op_y         (op_y),
        .approx_prod  (approx_prod),
        .approx_q     (approx_q),
        .exact_q      (exact_q),
        .err_sum      (err_sum),
        .err_max      (err_max),
        .sample_count (sample_count)
    );

endmodule

// File: apb_regs.sv
`timescale 1ns/100ps

module apb_regs (
    input  logic                            clk,
    input  logic                            rst,
    // APB slave
    input  logic                            psel,
    input  logic                            penable,
    input  logic                            pwrite,
    input  logic [approx_pkg::ADDR_W-1:0]   paddr,
    input  logic [approx_pkg::PROD_W-1:0]   pwdata,
    output logic [approx_pkg::PROD_W-1:0]   prdata,
    output logic                            pready,
    output logic                            pslverr,
    // To the datapath
    output logic [approx_pkg::OP_W-1:0]     op_x,
    output logic [approx_pkg::OP_W-1:0]     op_y,
    output logic                            start,
    output logic                            clear,
    // Results and statistics
    input  logic [approx_pkg::PROD_W-1:0]   approx_q,
    input  logic [approx_pkg::PROD_W-1:0]   exact_q,
    input  logic [approx_pkg::PROD_W-1:0]   err_sum,
    input  logic [approx_pkg::PROD_W-1:0]   err_max,
    input  logic [approx_pkg::PROD_W-1:0]   sample_count
);

    logic                          access;
    logic                          addr_hit;
    logic                          read_only;
    logic                          bad_access;
    logic                          wr_en;
    logic [approx_pkg::PROD_W-1:0] rd_mux;

    assign access = psel & penable;

    ////////////////////
    // Address decode
    ////////////////////

    always_comb begin
        addr_hit  = 1'b1;
        read_only = 1'b0;
        rd_mux    = '0;
        case (paddr)
            approx_pkg::REG_OP_X:
                rd_mux = {{(approx_pkg::PROD_W-approx_pkg::OP_W){op_x[approx_pkg::OP_W-1]}},
                          op_x};
            approx_pkg::REG_OP_Y:
                rd_mux = {{(approx_pkg::PROD_W-approx_pkg::OP_W){op_y[approx_pkg::OP_W-1]}},
                          op_y};
            approx_pkg::REG_CTRL:    rd_mux = '0;   // Clear is self-clearing
            approx_pkg::REG_APPROX: begin
                rd_mux    = approx_q;
                read_only = 1'b1;
            end
            approx_pkg::REG_EXACT: begin
                rd_mux    = exact_q;
                read_only = 1'b1;
            end
            approx_pkg::REG_ERR_SUM: begin
                rd_mux    = err_sum;
                read_only = 1'b1;
            end
            approx_pkg::REG_ERR_MAX: begin
                rd_mux    = err_max;
                read_only = 1'b1;
            end
            approx_pkg::REG_COUNT: begin
                rd_mux    = sample_count;
                read_only = 1'b1;
            end
            default: addr_hit = 1'b0;
        endcase
    end

    assign bad_access = ~addr_hit | (pwrite & read_only);
    assign wr_en      = access & pwrite & ~bad_access;   // Errored writes change nothing

    // Zero wait state, data and error valid in the access phase
    assign pready  = 1'b1;
    assign pslverr = access & bad_access;
    assign prdata  = (access & ~pwrite & addr_hit) ? rd_mux : '0;

    ////////////////////
    // Write side
    ////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            op_x  <= '0;
            op_y  <= '0;
            start <= 1'b0;
            clear <= 1'b0;
        end else begin
            start <= 1'b0;
            clear <= 1'b0;
            if (wr_en) begin
                case (paddr)
                    approx_pkg::REG_OP_X: op_x <= pwdata[approx_pkg::OP_W-1:0];
                    approx_pkg::REG_OP_Y: begin
                        op_y  <= pwdata[approx_pkg::OP_W-1:0];
                        start <= 1'b1;   // Sample taken once op_y has settled
                    end
                    approx_pkg::REG_CTRL: clear <= pwdata[approx_pkg::CTRL_CLEAR_BIT];
                    default: ;
                endcase
            end
        end
    end

endmodule

// File: err_metrics.sv
`timescale 1ns/100ps

module err_metrics (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            start,
    input  logic                            clear,
    input  logic [approx_pkg::OP_W-1:0]     op_x,
    input  logic [approx_pkg::OP_W-1:0]     op_y,
    input  logic [approx_pkg::PROD_W-1:0]   approx_prod,
    output logic [approx_pkg::PROD_W-1:0]   approx_q,
    output logic [approx_pkg::PROD_W-1:0]   exact_q,
    output logic [approx_pkg::PROD_W-1:0]   err_sum,
    output logic [approx_pkg::PROD_W-1:0]   err_max,
    output logic [approx_pkg::PROD_W-1:0]   sample_count
);

    logic signed [approx_pkg::PROD_W-1:0] exact;
    logic signed [approx_pkg::PROD_W:0]   diff;     // One extra bit, no overflow
    logic        [approx_pkg::PROD_W-1:0] abs_err;
    logic        [approx_pkg::PROD_W:0]   sum_ext;
    logic        [approx_pkg::PROD_W-1:0] sum_next;

    // Reference product from the ordinary signed multiply
    assign exact = $signed(op_x) * $signed(op_y);

    assign diff = $signed({approx_prod[approx_pkg::PROD_W-1], approx_prod}) -
                  $signed({exact[approx_pkg::PROD_W-1], exact});

    // Magnitude always fits in 32 bits
    assign abs_err = diff[approx_pkg::PROD_W] ? (~diff[approx_pkg::PROD_W-1:0] + 1'b1)
                                              : diff[approx_pkg::PROD_W-1:0];

    ////////////////////
    // Saturating sum
    ////////////////////

    assign sum_ext  = {1'b0, err_sum} + {1'b0, abs_err};
    assign sum_next = sum_ext[approx_pkg::PROD_W] ? approx_pkg::ERR_SUM_MAX
                                                  : sum_ext[approx_pkg::PROD_W-1:0];

    always_ff @(posedge clk) begin
        if (rst) begin
            approx_q     <= '0;
            exact_q      <= '0;
            err_sum      <= '0;
            err_max      <= '0;
            sample_count <= '0;
        end else begin
            if (start) begin
                approx_q <= approx_prod;
                exact_q  <= exact;
            end

            // Clear has priority, products stay
            if (clear) begin
                err_sum      <= '0;
                err_max      <= '0;
                sample_count <= '0;
            end else if (start) begin
                err_sum      <= sum_next;
                sample_count <= sample_count + 1'b1;
                if (abs_err > err_max)
                    err_max <= abs_err;
            end
        end
    end

endmodule

// File: approx_signed_mul.sv
`timescale 1ns/100ps

module approx_signed_mul (
    input  logic signed [approx_pkg::OP_W-1:0]   x,
    input  logic signed [approx_pkg::OP_W-1:0]   y,
    output logic        [approx_pkg::PROD_W-1:0] z
);

    ////////////////////
    // Partial products
    ////////////////////

    // Row i is y weighted by x[i], Baugh-Wooley sign handling
    logic [approx_pkg::OP_W-1:0] pp [approx_pkg::OP_W];

    // Sparse rows that replace the six lowest partial products
    logic [approx_pkg::PROD_W-1:0] cmp [5];

    logic [approx_pkg::PROD_W-1:0] acc;

    genvar i;
    generate
        for (i = 0; i < approx_pkg::OP_W - 1; i++) begin : g_row
            assign pp[i][approx_pkg::OP_W-2:0] = y[approx_pkg::OP_W-2:0] &
                                                 {(approx_pkg::OP_W-1){x[i]}};
            assign pp[i][approx_pkg::OP_W-1]   = ~(y[approx_pkg::OP_W-1] & x[i]);
        end
    endgenerate

    // Sign row, inverted the other way round
    assign pp[approx_pkg::OP_W-1][approx_pkg::OP_W-2:0] =
        ~(y[approx_pkg::OP_W-2:0] & {(approx_pkg::OP_W-1){x[approx_pkg::OP_W-1]}});
    assign pp[approx_pkg::OP_W-1][approx_pkg::OP_W-1] =
        y[approx_pkg::OP_W-1] & x[approx_pkg::OP_W-1];

    ////////////////////
    // Compressed low rows
    ////////////////////

    // Rows 0 to 5 are mostly dropped
    // The survivors are merged pairwise with AND, OR or XOR
    always_comb begin
        for (int k = 0; k < 5; k++) begin
            cmp[k] = '0;
        end

        // First row collects most of the merged terms
        cmp[0][3]  = pp[0][2] & pp[1][1];
        cmp[0][4]  = pp[0][4] | pp[1][3];
        cmp[0][8]  = pp[2][5] & pp[3][4];
        cmp[0][10] = pp[2][8] ^ pp[3][7];   // Half adder sum
        cmp[0][11] = pp[2][8] & pp[3][7];   // and its carry
        cmp[0][12] = pp[4][7] | pp[5][6];
        cmp[0][14] = pp[2][11] & pp[3][10];
        cmp[0][16] = pp[2][13] & pp[3][12];
        cmp[0][17] = pp[1][15];             // Sign term of row 1, moved up one place
        cmp[0][18] = pp[2][15] & pp[3][14];
        cmp[0][19] = pp[4][15] ^ pp[5][14];
        cmp[0][20] = pp[4][15] & pp[5][14];

        cmp[1][11] = pp[4][6] & pp[5][5];
        cmp[1][14] = pp[4][10] ^ pp[5][9];
        cmp[1][17] = pp[2][14] | pp[3][13];
        cmp[1][18] = pp[3][15];
        cmp[1][20] = pp[5][15];

        cmp[2][17] = pp[2][15] ^ pp[3][14];
        cmp[2][18] = pp[4][13] & pp[5][12];

        cmp[3][17] = pp[4][12] | pp[5][11];
        cmp[3][18] = pp[4][14] ^ pp[5][13];

        cmp[4][17] = pp[4][13] ^ pp[5][12];
    end

    ////////////////////
    // Final summation
    ////////////////////

    always_comb begin
        logic [approx_pkg::PROD_W-1:0] row;

        acc = '0;

        // Upper rows go in exact, shifted into place
        for (int r = 6; r < approx_pkg::OP_W; r++) begin
            row = '0;
            row[approx_pkg::OP_W-1:0] = pp[r];
            acc = acc + (row << r);
        end

        // Correction one of the sign row, top of the product
        acc = acc + {1'b1, {(approx_pkg::PROD_W-1){1'b0}}};

        for (int k = 0; k < 5; k++) begin
            acc = acc + cmp[k];
        end
    end

    assign z = acc;   // Wraps modulo 2^32 like the array it models

endmodule

// File: approx_pkg.sv
package approx_pkg;

    ////////////////////
    // Datapath widths
    ////////////////////

    localparam int OP_W   = 16;   // Signed operand width
    localparam int PROD_W = 32;   // Product and APB data width

    ////////////////////
    // APB register map
    ////////////////////

    localparam int ADDR_W = 8;

    localparam logic [ADDR_W-1:0] REG_OP_X    = 8'h00;  // RW, low 16 bits kept
    localparam logic [ADDR_W-1:0] REG_OP_Y    = 8'h04;  // RW, write launches a sample
    localparam logic [ADDR_W-1:0] REG_CTRL    = 8'h08;  // WO, reads as zero
    localparam logic [ADDR_W-1:0] REG_APPROX  = 8'h0C;  // RO
    localparam logic [ADDR_W-1:0] REG_EXACT   = 8'h10;  // RO
    localparam logic [ADDR_W-1:0] REG_ERR_SUM = 8'h14;  // RO
    localparam logic [ADDR_W-1:0] REG_ERR_MAX = 8'h18;  // RO
    localparam logic [ADDR_W-1:0] REG_COUNT   = 8'h1C;  // RO

    // Control register fields
    localparam int CTRL_CLEAR_BIT = 0;

    // Error sum sticks here instead of wrapping
    localparam logic [PROD_W-1:0] ERR_SUM_MAX = {PROD_W{1'b1}};

endpackage
